/* Makefile */
VERILATOR  ?= verilator
TOP        ?= fetch_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* common/bus_pkg.sv */
package bus_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    localparam logic [2:0] AXI_SIZE_4B     = 3'b010;
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

/* common/core_pkg.sv */
`include "fetch_settings.svh"

package core_pkg;

    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = $clog2(`ICACHE_LINES);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [31:0] inst_t;

    // Fetch address, stepped whole by the PC logic and split by the cache
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } pc_t;

    // Core to fetch steering, both flags are single-cycle strobes
    typedef struct packed {
        logic strobe;
        logic stop;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        pc_t   pc;
        inst_t inst;
    } fetch_out_t;

    // flush is a one-cycle pulse toward the cache
    typedef struct packed {
        logic enable;
        logic flush;
    } cache_cfg_t;

endpackage

/* common/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ----------------------------------------------------------------------
// Fetch front end build settings
// ----------------------------------------------------------------------

// First address fetched after reset
`define FETCH_RESET_PC 32'h3000_0000

// Direct-mapped cache depth, one word per line, power of two
`define ICACHE_LINES 16

// ID driven on every AXI read request
`define FETCH_AXI_ID 0

`endif

/* fetch/fetch_unit.sv */
`include "fetch_settings.svh"

module fetch_unit (
    input  logic                 clock,
    input  logic                 reset,
    input  core_pkg::redirect_t  redirect,
    input  logic                 out_ready,
    input  logic                 resp,
    input  core_pkg::inst_t      resp_inst,
    output logic                 out_valid,
    output core_pkg::fetch_out_t out,
    output logic                 req,
    output core_pkg::pc_t        req_pc
);
    import core_pkg::*;

    pc_t  pc;
    pc_t  pc_next;
    pc_t  pend_target;
    pc_t  take_target;
    logic pend_redirect;
    logic pend_stop;
    logic take_stop;
    logic take_redirect;
    logic start;
    logic take;

    assign take = out_valid && out_ready;

    // Merge pending requests with one arriving on the handshake cycle
    assign take_stop     = pend_stop || redirect.stop;
    assign take_redirect = pend_redirect || redirect.strobe;
    assign take_target   = redirect.strobe ? redirect.target : pend_target;

    // Stop beats redirect beats sequential step
    always_comb begin
        if (take_stop) begin
            pc_next = pc;
        end else if (take_redirect) begin
            pc_next = take_target;
        end else begin
            pc_next.raw = pc.raw + 32'd4;
        end
    end

    // ----------------------------------------------------------------------
    // Program counter and request issue
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc.raw        <= `FETCH_RESET_PC;
            start         <= 1'b1;
            req           <= 1'b0;
            pend_redirect <= 1'b0;
            pend_stop     <= 1'b0;
        end else begin
            start <= 1'b0;
            // One request after reset, then one per accepted word
            req   <= start || take;
            if (take) begin
                pc            <= pc_next;
                pend_redirect <= 1'b0;
                pend_stop     <= 1'b0;
            end else begin
                if (redirect.strobe) pend_redirect <= 1'b1;
                if (redirect.stop) pend_stop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (redirect.strobe && !take) begin
            pend_target <= redirect.target;
        end
    end

    assign req_pc = pc;

    // ----------------------------------------------------------------------
    // Decode output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (resp) begin
            out_valid <= 1'b1;
        end else if (take) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (resp) begin
            out.pc   <= pc;
            out.inst <= resp_inst;
        end
    end

    // No overlap between an open cache request and a held word
    req_while_held: assert property (@(posedge clock) disable iff (reset)
        $rose(req) |-> !out_valid);
    resp_while_held: assert property (@(posedge clock) disable iff (reset)
        resp |-> !out_valid);

endmodule

/* fetch/icache.sv */
`include "fetch_settings.svh"

module icache (
    input  logic                clock,
    input  logic                reset,
    input  logic                req,
    input  core_pkg::pc_t       req_pc,
    input  core_pkg::cache_cfg_t cfg,
    input  logic                ar_ready,
    input  logic                r_valid,
    input  bus_pkg::axi_r_t     r,
    output logic                resp,
    output core_pkg::inst_t     resp_inst,
    output logic                resp_error,
    output logic                hit,
    output logic                miss,
    output logic                ar_valid,
    output bus_pkg::axi_ar_t    ar,
    output logic                r_ready
);
    import core_pkg::*;
    import bus_pkg::*;

    localparam int LINES = `ICACHE_LINES;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_WAIT
    } state_e;

    state_e           state;
    pc_t              miss_pc;
    logic [LINES-1:0] line_valid;
    logic [TAG_W-1:0] tag_mem [LINES];
    inst_t            data_mem [LINES];
    logic             lookup_hit;
    logic             r_okay;
    logic             fill;

    // Disabled cache never hits, so every access goes to the bus
    assign lookup_hit = cfg.enable && line_valid[req_pc.fields.index]
                        && (tag_mem[req_pc.fields.index] == req_pc.fields.tag);

    assign r_okay  = (r.resp == OKAY);
    assign fill    = (state == S_WAIT) && r_valid && r_okay && cfg.enable;
    assign r_ready = 1'b1;

    // Single-beat word read at the latched miss address
    assign ar.addr  = miss_pc.raw;
    assign ar.id    = 4'(`FETCH_AXI_ID);
    assign ar.len   = 8'd0;
    assign ar.size  = AXI_SIZE_4B;
    assign ar.burst = AXI_BURST_FIXED;

    // ----------------------------------------------------------------------
    // Lookup and refill FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            ar_valid   <= 1'b0;
            resp       <= 1'b0;
            resp_error <= 1'b0;
            hit        <= 1'b0;
            miss       <= 1'b0;
        end else begin
            resp       <= 1'b0;
            resp_error <= 1'b0;
            hit        <= 1'b0;
            miss       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req && lookup_hit) begin
                        resp <= 1'b1;
                        hit  <= 1'b1;
                    end else if (req) begin
                        miss     <= 1'b1;
                        ar_valid <= 1'b1;
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (r_valid) begin
                        resp       <= 1'b1;
                        resp_error <= !r_okay;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && req) begin
            miss_pc   <= req_pc;
            resp_inst <= data_mem[req_pc.fields.index];
        end else if (state == S_WAIT && r_valid) begin
            resp_inst <= r.data;
        end
        if (fill) begin
            tag_mem[miss_pc.fields.index]  <= miss_pc.fields.tag;
            data_mem[miss_pc.fields.index] <= r.data;
        end
    end

    // Flush overrides a fill landing on the same edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            line_valid <= '0;
        end else if (cfg.flush) begin
            line_valid <= '0;
        end else if (fill) begin
            line_valid[miss_pc.fields.index] <= 1'b1;
        end
    end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));
    // Only single-beat reads are ever outstanding
    r_single_beat: assert property (@(posedge clock) disable iff (reset)
        r_valid |-> r.last && state == S_WAIT);

endmodule

/* logic/cache_control.sv */
module cache_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  core_pkg::cache_cfg_t cfg_data,
    input  logic                 hit,
    input  logic                 miss,
    output core_pkg::cache_cfg_t cfg,
    output logic [31:0]          hit_count,
    output logic [31:0]          miss_count
);

    logic clear_counts;

    assign clear_counts = cfg_write && cfg_data.flush;

    // Enable is sticky, flush lasts exactly one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cfg.enable <= 1'b1;
            cfg.flush  <= 1'b0;
        end else begin
            cfg.flush <= clear_counts;
            if (cfg_write) cfg.enable <= cfg_data.enable;
        end
    end

    // ----------------------------------------------------------------------
    // Saturating performance counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else if (clear_counts) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit && hit_count != '1) hit_count <= hit_count + 32'd1;
            if (miss && miss_count != '1) miss_count <= miss_count + 32'd1;
        end
    end

    // Cache reports each lookup exactly one way
    hit_miss_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(hit && miss));

endmodule

/* logic/fetch_top.sv */
module fetch_top (
    input  logic                 clock,
    input  logic                 reset,
    input  core_pkg::redirect_t  redirect,
    input  logic                 out_ready,
    output logic                 out_valid,
    output core_pkg::fetch_out_t out,
    output logic                 resp_error,
    input  logic                 cfg_write,
    input  core_pkg::cache_cfg_t cfg_data,
    output logic [31:0]          hit_count,
    output logic [31:0]          miss_count,
    output logic                 ar_valid,
    input  logic                 ar_ready,
    output bus_pkg::axi_ar_t     ar,
    input  logic                 r_valid,
    output logic                 r_ready,
    input  bus_pkg::axi_r_t      r
);
    import core_pkg::*;

    // Fetch to cache request link
    logic       req;
    pc_t        req_pc;
    logic       resp;
    inst_t      resp_inst;

    // Cache to control block
    logic       hit;
    logic       miss;
    cache_cfg_t cfg;

    fetch_unit fetch_unit_inst (
        .clock     (clock),
        .reset     (reset),
        .redirect  (redirect),
        .out_ready (out_ready),
        .resp      (resp),
        .resp_inst (resp_inst),
        .out_valid (out_valid),
        .out       (out),
        .req       (req),
        .req_pc    (req_pc)
    );

    icache icache_inst (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .req_pc     (req_pc),
        .cfg        (cfg),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r          (r),
        .resp       (resp),
        .resp_inst  (resp_inst),
        .resp_error (resp_error),
        .hit        (hit),
        .miss       (miss),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .r_ready    (r_ready)
    );

    cache_control cache_control_inst (
        .clock      (clock),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_data   (cfg_data),
        .hit        (hit),
        .miss       (miss),
        .cfg        (cfg),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

endmodule

/* verification/clock_gen.sv */
module clock_gen (
    output logic clock
);

    // Free-running clock, period of 4 time units
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

endmodule

/* verification/fetch_tb.sv */
`include "fetch_settings.svh"

module fetch_tb;
    import core_pkg::*;
    import bus_pkg::*;

    localparam int          NROWS    = 22;
    localparam int          LINES    = `ICACHE_LINES;
    localparam int          IDX_W    = $clog2(LINES);
    localparam logic [31:0] B        = `FETCH_RESET_PC;
    localparam logic [31:0] E        = 32'h4000_0000;
    localparam logic [31:0] PATTERN  = 32'h5a5a_5a5a;
    localparam logic [31:0] SEED     = 32'hb004;
    localparam int          WATCHDOG = NROWS * 200 * 4;

    typedef struct packed {
        logic        strobe;
        logic [31:0] target;
        logic        stop;
        logic [7:0]  stall;
        logic        cfg_wr;
        cache_cfg_t  cfg;
        logic [31:0] exp_pc;
    } row_t;

    // strobe, target, stop, stall, cfg write, {enable, flush}, expected pc
    row_t rows [NROWS] = '{
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b0, 2'b00, B},
        '{1'b0, 32'h0, 1'b0, 8'd2, 1'b0, 2'b00, B + 32'h4},
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'h8},
        '{1'b1, B, 1'b0, 8'd1, 1'b0, 2'b00, B + 32'hc},
        '{1'b0, 32'h0, 1'b1, 8'd3, 1'b0, 2'b00, B},
        '{1'b1, B + 32'h100, 1'b1, 8'd0, 1'b0, 2'b00, B},
        '{1'b1, B + 32'h100, 1'b0, 8'd2, 1'b0, 2'b00, B},
        '{1'b1, B, 1'b0, 8'd1, 1'b0, 2'b00, B + 32'h100},
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b0, 2'b00, B},
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'h4},
        '{1'b0, 32'h0, 1'b0, 8'd2, 1'b1, 2'b11, B + 32'h8},
        '{1'b1, B, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'hc},
        '{1'b0, 32'h0, 1'b0, 8'd1, 1'b0, 2'b00, B},
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b1, 2'b00, B + 32'h4},
        '{1'b1, B + 32'h4, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'h8},
        '{1'b1, B + 32'h4, 1'b0, 8'd3, 1'b1, 2'b10, B + 32'h4},
        '{1'b1, E, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'h4},
        '{1'b1, E, 1'b0, 8'd2, 1'b0, 2'b00, E},
        '{1'b1, B + 32'h200, 1'b0, 8'd4, 1'b0, 2'b00, E},
        '{1'b0, 32'h0, 1'b0, 8'd4, 1'b0, 2'b00, B + 32'h200},
        '{1'b0, 32'h0, 1'b0, 8'd0, 1'b0, 2'b00, B + 32'h204},
        '{1'b0, 32'h0, 1'b0, 8'd1, 1'b0, 2'b00, B + 32'h208}
    };

    logic        clock;
    logic        reset      = 1'b1;
    redirect_t   redirect   = '0;
    logic        out_ready  = 1'b0;
    logic        out_valid;
    fetch_out_t  out;
    logic        resp_error;
    logic        cfg_write  = 1'b0;
    cache_cfg_t  cfg_data   = '0;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic        ar_valid;
    logic        ar_ready   = 1'b0;
    axi_ar_t     ar;
    logic        r_valid    = 1'b0;
    logic        r_ready;
    axi_r_t      r          = '0;

    logic        err_seen    = 1'b0;
    logic [31:0] expect_addr = '0;
    int          errors      = 0;

    // Reference cache state
    logic [LINES-1:0] model_valid  = '0;
    logic [31:0]      model_tag [LINES];
    logic             model_enable = 1'b1;
    logic [31:0]      model_hits   = '0;
    logic [31:0]      model_misses = '0;

    clock_gen clock_gen_inst (
        .clock (clock)
    );

    fetch_top fetch_top_inst (
        .clock      (clock),
        .reset      (reset),
        .redirect   (redirect),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out        (out),
        .resp_error (resp_error),
        .cfg_write  (cfg_write),
        .cfg_data   (cfg_data),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r)
    );

    // ----------------------------------------------------------------------
    // AXI read memory model
    // ----------------------------------------------------------------------
    initial begin : memory_model
        int          wait_cycles;
        logic        busy;
        logic [31:0] addr;
        logic [3:0]  id;
        axi_ar_t     exp_ar;
        void'($urandom(SEED));
        busy = 1'b0;
        wait_cycles = 0;
        addr = '0;
        id = '0;
        exp_ar = '0;
        forever begin
            @(posedge clock);
            if (r_valid) begin
                check_flag("r_ready", r_ready, 1'b1);
            end
            r_valid  <= 1'b0;
            ar_ready <= ($urandom_range(3, 0) != 0);
            if (reset) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cycles == 0) begin
                    busy = 1'b0;
                    r_valid <= 1'b1;
                    r.data  <= addr ^ PATTERN;
                    r.resp  <= (addr >= E) ? SLVERR : OKAY;
                    r.last  <= 1'b1;
                    r.id    <= id;
                end else begin
                    wait_cycles--;
                end
            end else if (ar_valid && ar_ready) begin
                // Single 4-byte beat, fixed burst, at the address being fetched
                exp_ar.addr  = expect_addr;
                exp_ar.id    = 4'(`FETCH_AXI_ID);
                exp_ar.len   = 8'd0;
                exp_ar.size  = 3'b010;
                exp_ar.burst = 2'b00;
                check_ar("ar", ar, exp_ar);
                busy = 1'b1;
                addr = ar.addr;
                id = ar.id;
                wait_cycles = $urandom_range(3, 0);
            end
        end
    end

    // Error pulse leads out_valid by a cycle and is held for the word
    always @(posedge clock) begin
        if (reset) begin
            err_seen <= 1'b0;
        end else if (resp_error) begin
            err_seen <= 1'b1;
        end else if (out_valid && out_ready) begin
            err_seen <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks and reference model
    // ----------------------------------------------------------------------
    task automatic check_out(input string name, input fetch_out_t got, input fetch_out_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got pc=%h inst=%h expected pc=%h inst=%h", $time, name,
                     got.pc.raw, got.inst, exp.pc.raw, exp.inst);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ar(input string name, input axi_ar_t got, input axi_ar_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Direct-mapped lookup with the index just above the byte offset
    task automatic model_access(input logic [31:0] pc);
        logic [IDX_W-1:0] idx;
        logic [31:0]      tag;
        idx = pc[IDX_W+1:2];
        tag = pc >> (IDX_W + 2);
        if (model_enable && model_valid[idx] && model_tag[idx] == tag) begin
            model_hits = model_hits + 32'd1;
        end else begin
            model_misses = model_misses + 32'd1;
            if (model_enable && pc < E) begin
                model_valid[idx] = 1'b1;
                model_tag[idx] = tag;
            end
        end
    endtask

    task automatic run_row(input int idx, input row_t row);
        int         fails_before;
        fetch_out_t exp_out;
        logic       exp_err;
        fails_before = errors;
        expect_addr = row.exp_pc;
        exp_out.pc.raw = row.exp_pc;
        exp_out.inst = row.exp_pc ^ PATTERN;
        exp_err = (row.exp_pc >= E);
        @(negedge clock);
        while (!out_valid) begin
            @(negedge clock);
        end
        model_access(row.exp_pc);
        check_out("out", out, exp_out);
        check_flag("resp_error", err_seen, exp_err);
        check_count("hit_count", hit_count, model_hits);
        check_count("miss_count", miss_count, model_misses);
        // Steering goes in while the word is held, so it lands on the next fetch
        @(posedge clock);
        redirect.strobe     <= row.strobe;
        redirect.stop       <= row.stop;
        redirect.target.raw <= row.target;
        cfg_write           <= row.cfg_wr;
        cfg_data            <= row.cfg;
        @(posedge clock);
        redirect  <= '0;
        cfg_write <= 1'b0;
        repeat (row.stall) begin
            @(negedge clock);
            check_out("out", out, exp_out);
            check_flag("out_valid", out_valid, 1'b1);
            @(posedge clock);
        end
        out_ready <= 1'b1;
        @(negedge clock);
        check_out("out", out, exp_out);
        check_flag("out_valid", out_valid, 1'b1);
        @(posedge clock);
        out_ready <= 1'b0;
        if (row.cfg_wr) begin
            model_enable = row.cfg.enable;
            if (row.cfg.flush) begin
                model_valid = '0;
                model_hits = '0;
                model_misses = '0;
            end
        end
        $display("row %0d pc %h %s", idx, row.exp_pc, (errors == fails_before) ? "ok" : "FAILED");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        repeat (3) @(posedge clock);
        // Idle outputs while reset is held
        @(negedge clock);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("ar_valid", ar_valid, 1'b0);
        check_flag("resp_error", resp_error, 1'b0);
        check_count("hit_count", hit_count, 32'd0);
        check_count("miss_count", miss_count, 32'd0);
        @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < NROWS; i++) begin
            run_row(i, rows[i]);
        end
        $display("%0d rows run, %0d checks failed", NROWS, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before every row reached its decode handshake");
        $display("tests failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/core_pkg.sv
common/bus_pkg.sv
fetch/fetch_unit.sv
fetch/icache.sv
logic/cache_control.sv
logic/fetch_top.sv
verification/clock_gen.sv
verification/fetch_tb.sv
